//--- csc_sync.f
+incdir+testbench
rtl/csc_sync_pkg.sv
rtl/csc_sync_regs.sv
rtl/link_qualify.sv
rtl/sync_done_delay.sv
rtl/csc_sync_mon.sv
rtl/csc_sync_top.sv
testbench/csc_sync_tb.sv

//--- rtl/csc_sync_mon.sv
`timescale 1ns/1ps

module csc_sync_mon #(
  parameter int n_links = 5
) (
  input  logic                                         clock,
  input  logic                                         rst,
  input  logic [n_links*csc_sync_pkg::marker_bits-1:0] kchar,          // Link i in byte i
  input  logic [n_links-1:0]                           skip,           // From the link qualifier
  input  logic                                         ready,          // Power-up done, no resync
  input  logic                                         done_delayed,   // All links resynced
  input  logic                                         lostsync_clear, // Host write to status
  output logic                                         synced,
  output logic                                         lostsync
);

  localparam int mb = csc_sync_pkg::marker_bits;

  // --------------------------------------------------
  // Split the flat bus into marker bytes
  // --------------------------------------------------

  csc_sync_pkg::marker_t marker [n_links];  // One decoded marker per link

  always_comb begin
    for (int i = 0; i < n_links; i++) begin
      marker[i].raw = kchar[i*mb +: mb];
    end
  end

  // --------------------------------------------------
  // Table and agreement checks
  // --------------------------------------------------

  logic [mb-1:0] any_ones;   // OR of unskipped markers
  logic [mb-1:0] all_ones;   // AND of unskipped markers
  logic          all_valid;  // Every unskipped marker is in the table
  logic          all_skip;   // No link takes part this cycle
  logic          in_sync;    // This cycle looks healthy

  // A bit that differs between two links shows up as 1 in the OR and 0 in the AND
  // Skipped links are forced to 0 in the OR and 1 in the AND so they never disturb either
  always_comb begin
    any_ones  = '0;
    all_ones  = '1;
    all_valid = 1'b1;
    for (int i = 0; i < n_links; i++) begin
      if (!skip[i]) begin
        any_ones = any_ones | marker[i].raw;
        all_ones = all_ones & marker[i].raw;
        if (marker[i].fields.code != csc_sync_pkg::marker_code_valid) begin
          all_valid = 1'b0;  // K-character outside the frame marker table
        end
      end
    end
  end

  assign all_skip = &skip;

  // With every link skipped there is nothing to disagree about
  assign in_sync = all_skip || ((any_ones == all_ones) && all_valid);

  // --------------------------------------------------
  // Sync flags
  // --------------------------------------------------

  logic hold_idle;  // Link is not yet trusted after power-up or resync

  assign hold_idle = !ready || !done_delayed;

  always_ff @(posedge clock) begin
    if (rst) begin
      synced   <= 1'b1;
      lostsync <= 1'b0;
    end else if (hold_idle) begin
      synced   <= 1'b1;  // Idle state reads as in sync
      lostsync <= 1'b0;  // Every resync starts a fresh history
    end else begin
      synced   <= in_sync;
      // A loss in the clear cycle itself still latches
      lostsync <= (lostsync && !lostsync_clear) || !in_sync;
    end
  end

endmodule

//--- rtl/csc_sync_pkg.sv
package csc_sync_pkg;

  // --------------------------------------------------
  // Link count and marker byte layout
  // --------------------------------------------------

  localparam int n_links_default = 5;  // One fiber per front-end cathode board
  localparam int marker_bits     = 8;  // One K-character per link per crossing

  // The overflow marker means the board dropped data, so the link says nothing about sync
  localparam logic [marker_bits-1:0] marker_overflow = 8'hFC;

  // Bits 4:1 of every legal frame marker read as E
  // This covers 1C 3C 5C 7C 9C BC DC and FD and rejects the other K-characters
  localparam logic [3:0] marker_code_valid = 4'hE;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  localparam int delay_bits = 4;  // Resync-done delay setting, taps 0 to 15

  localparam logic [1:0] addr_fiber_enable = 2'd0;  // Per-link enable mask
  localparam logic [1:0] addr_rxd_delay    = 2'd1;  // Resync-done delay
  localparam logic [1:0] addr_status       = 2'd2;  // Read synced and lostsync, write clears

  // Cycles of locked clock before the monitor may leave its idle state
  localparam int powerup_cycles_default = 2;

  // --------------------------------------------------
  // Marker byte, seen either whole or split into fields
  // --------------------------------------------------

  typedef struct packed {
    logic [2:0] tag;   // Crossing tag carried in the top three bits
    logic [3:0] code;  // Table code, must equal marker_code_valid
    logic       low;   // Bit 0 tells FD apart from the others
  } marker_fields_t;

  typedef union packed {
    logic [marker_bits-1:0] raw;     // Whole byte for compares across links
    marker_fields_t         fields;  // Decoded view for the table check
  } marker_t;

endpackage

//--- rtl/csc_sync_regs.sv
`timescale 1ns/1ps

module csc_sync_regs #(
  parameter int n_links = 5
) (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                reg_we,          // Single-cycle write strobe
  input  logic [1:0]                          reg_addr,
  input  logic [7:0]                          reg_wdata,
  input  logic                                synced,          // Live sync flag from the monitor
  input  logic                                lostsync,        // Sticky loss flag from the monitor
  output logic [7:0]                          reg_rdata,       // Combinational readback
  output logic [n_links-1:0]                  fiber_enable,
  output logic [csc_sync_pkg::delay_bits-1:0] rxd_delay,
  output logic                                lostsync_clear   // High in the write cycle only
);

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------

  logic we_enable;  // Write hits the fiber enable mask
  logic we_delay;   // Write hits the resync-done delay
  logic we_status;  // Write hits the status register

  assign we_enable = reg_we && (reg_addr == csc_sync_pkg::addr_fiber_enable);
  assign we_delay  = reg_we && (reg_addr == csc_sync_pkg::addr_rxd_delay);
  assign we_status = reg_we && (reg_addr == csc_sync_pkg::addr_status);

  // The status register holds no state of its own
  // A write there is passed straight on so the monitor drops lostsync at the same edge
  assign lostsync_clear = we_status;

  // All fibers come up enabled and the delay at its shortest tap
  always_ff @(posedge clock) begin
    if (rst) begin
      fiber_enable <= '1;
      rxd_delay    <= '0;
    end else begin
      if (we_enable) begin
        fiber_enable <= reg_wdata[n_links-1:0];  // Bits above the link count are dropped
      end
      if (we_delay) begin
        rxd_delay <= reg_wdata[csc_sync_pkg::delay_bits-1:0];
      end
    end
  end

  // --------------------------------------------------
  // Readback
  // --------------------------------------------------

  // Unused upper bits read as zero, and so does any undefined address
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      csc_sync_pkg::addr_fiber_enable: begin
        reg_rdata[n_links-1:0] = fiber_enable;
      end
      csc_sync_pkg::addr_rxd_delay: begin
        reg_rdata[csc_sync_pkg::delay_bits-1:0] = rxd_delay;
      end
      csc_sync_pkg::addr_status: begin
        reg_rdata[0] = synced;    // Live flag
        reg_rdata[1] = lostsync;  // Sticky flag
      end
      default: begin
        reg_rdata = '0;
      end
    endcase
  end

endmodule

//--- rtl/csc_sync_top.sv
`timescale 1ns/1ps

module csc_sync_top #(
  parameter int n_links        = csc_sync_pkg::n_links_default,
  parameter int powerup_cycles = csc_sync_pkg::powerup_cycles_default
) (
  input  logic                                         clock,
  input  logic                                         rst,
  input  logic                                         clk_lock,
  input  logic                                         ttc_resync,
  input  logic [n_links*csc_sync_pkg::marker_bits-1:0] kchar,       // Link i in byte i
  input  logic [n_links-1:0]                           link_good,
  input  logic [n_links-1:0]                           sync_done,
  input  logic                                         reg_we,
  input  logic [1:0]                                   reg_addr,
  input  logic [7:0]                                   reg_wdata,
  output logic [7:0]                                   reg_rdata,
  output logic                                         synced,      // Live, all links agree
  output logic                                         lostsync     // Sticky until cleared
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  logic [n_links-1:0]                  fiber_enable;    // Host mask of active fibers
  logic [csc_sync_pkg::delay_bits-1:0] rxd_delay;       // Resync-done delay tap
  logic                                lostsync_clear;  // Status write strobe
  logic [n_links-1:0]                  skip;            // Links left out this cycle
  logic                                ready;           // Power-up done and no resync
  logic                                done_delayed;    // Delayed all-links resync done

  csc_sync_regs #(.n_links(n_links)) i_csc_sync_regs (
    .clock          (clock),
    .rst            (rst),
    .reg_we         (reg_we),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .synced         (synced),
    .lostsync       (lostsync),
    .reg_rdata      (reg_rdata),
    .fiber_enable   (fiber_enable),
    .rxd_delay      (rxd_delay),
    .lostsync_clear (lostsync_clear)
  );

  link_qualify #(.n_links(n_links)) i_link_qualify (
    .clock        (clock),
    .rst          (rst),
    .kchar        (kchar),
    .link_good    (link_good),
    .fiber_enable (fiber_enable),
    .skip         (skip)
  );

  sync_done_delay #(
    .powerup_cycles (powerup_cycles),
    .n_links        (n_links)
  ) i_sync_done_delay (
    .clock        (clock),
    .rst          (rst),
    .clk_lock     (clk_lock),
    .ttc_resync   (ttc_resync),
    .sync_done    (sync_done),
    .rxd_delay    (rxd_delay),
    .ready        (ready),
    .done_delayed (done_delayed)
  );

  csc_sync_mon #(.n_links(n_links)) i_csc_sync_mon (
    .clock          (clock),
    .rst            (rst),
    .kchar          (kchar),
    .skip           (skip),
    .ready          (ready),
    .done_delayed   (done_delayed),
    .lostsync_clear (lostsync_clear),
    .synced         (synced),
    .lostsync       (lostsync)
  );

endmodule

//--- rtl/link_qualify.sv
`timescale 1ns/1ps

module link_qualify #(
  parameter int n_links = 5
) (
  input  logic                                       clock,
  input  logic                                       rst,
  input  logic [n_links*csc_sync_pkg::marker_bits-1:0] kchar,         // Link i in byte i
  input  logic [n_links-1:0]                         link_good,     // Receiver reports a clean link
  input  logic [n_links-1:0]                         fiber_enable,  // Mask from the register block
  output logic [n_links-1:0]                         skip           // Leave this link out of the check
);

  localparam int mb = csc_sync_pkg::marker_bits;

  // --------------------------------------------------
  // Link-good history
  // --------------------------------------------------

  logic [n_links-1:0] good_r1;  // link_good one cycle ago
  logic [n_links-1:0] good_r2;  // link_good two cycles ago

  // A link that just recovered may still carry stale markers for a couple of crossings
  // Clearing the history on reset keeps every link out of the check until it has been good twice
  always_ff @(posedge clock) begin
    if (rst) begin
      good_r1 <= '0;
      good_r2 <= '0;
    end else begin
      good_r1 <= link_good;
      good_r2 <= good_r1;
    end
  end

  // --------------------------------------------------
  // Skip decision per link
  // --------------------------------------------------

  logic [n_links-1:0] is_overflow;  // Link carries the overflow marker this cycle

  always_comb begin
    for (int i = 0; i < n_links; i++) begin
      is_overflow[i] = (kchar[i*mb +: mb] == csc_sync_pkg::marker_overflow);
    end
  end

  // Any one reason is enough to skip a link
  always_comb begin
    for (int i = 0; i < n_links; i++) begin
      skip[i] = is_overflow[i]      // Board overflowed, marker means nothing
             || !fiber_enable[i]    // Fiber switched off by the host
             || !link_good[i]       // Bad right now
             || !good_r1[i]         // Bad one cycle ago
             || !good_r2[i];        // Bad two cycles ago
    end
  end

endmodule

//--- rtl/sync_done_delay.sv
`timescale 1ns/1ps

module sync_done_delay #(
  parameter int powerup_cycles = 2,
  parameter int n_links        = 5
) (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                clk_lock,      // Power-up count only runs while locked
  input  logic                                ttc_resync,    // Level, holds ready low while high
  input  logic [n_links-1:0]                  sync_done,     // Per-link resync complete
  input  logic [csc_sync_pkg::delay_bits-1:0] rxd_delay,     // Tap select for done_delayed
  output logic                                ready,
  output logic                                done_delayed
);

  // Counter wide enough to hold powerup_cycles, and never zero bits wide
  localparam int cnt_bits   = $clog2(powerup_cycles + 2);
  localparam int hist_depth = 2 ** csc_sync_pkg::delay_bits;  // Sixteen taps

  // --------------------------------------------------
  // Power-up and resync ready
  // --------------------------------------------------

  logic [cnt_bits-1:0] pwr_cnt;   // Locked cycles seen since reset
  logic                power_up;  // Counter has reached its end value

  assign power_up = (pwr_cnt == cnt_bits'(powerup_cycles));

  // Counter stops at powerup_cycles and stays there until the next reset
  always_ff @(posedge clock) begin
    if (rst) begin
      pwr_cnt <= '0;
    end else if (clk_lock && !power_up) begin
      pwr_cnt <= pwr_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      ready <= 1'b0;
    end else begin
      ready <= power_up && !ttc_resync;  // Any resync cycle drops ready for one edge at least
    end
  end

  // --------------------------------------------------
  // All-links resync-done delay line
  // --------------------------------------------------

  logic                  all_done;  // Every link has finished its resync
  logic [hist_depth-1:0] done_hist; // Bit k is all_done from k+1 cycles ago

  assign all_done = &sync_done;

  always_ff @(posedge clock) begin
    if (rst) begin
      done_hist <= '0;
    end else begin
      done_hist <= {done_hist[hist_depth-2:0], all_done};
    end
  end

  // Tap zero already sits one cycle behind all_done, so the delay is rxd_delay plus one
  assign done_delayed = done_hist[rxd_delay];

endmodule

//--- testbench/csc_sync_tests.svh
// --------------------------------------------------
// Reset values and register access
// --------------------------------------------------

task automatic reset_and_registers();
  logic [7:0] data;
  logic [7:0] all_on;
  test_name = "reset_and_registers";
  all_on    = 8'((1 << n_links) - 1);
  read_reg(csc_sync_pkg::addr_fiber_enable, data);
  compare_byte("enable mask after reset", all_on, data);
  read_reg(csc_sync_pkg::addr_rxd_delay, data);
  compare_byte("delay after reset", 8'h00, data);
  read_reg(csc_sync_pkg::addr_status, data);
  compare_byte("status after reset", 8'h01, data);  // Synced while idle
  settle_link();
  write_reg(csc_sync_pkg::addr_fiber_enable, 8'hF5);
  write_reg(csc_sync_pkg::addr_rxd_delay, 8'h0A);
  write_reg(2'd3, 8'hFF);  // Unmapped, must change nothing
  read_reg(csc_sync_pkg::addr_fiber_enable, data);
  compare_byte("enable mask readback", 8'hF5 & all_on, data);
  read_reg(csc_sync_pkg::addr_rxd_delay, data);
  compare_byte("delay readback", 8'h0A, data);
  write_reg(csc_sync_pkg::addr_fiber_enable, all_on);
  write_reg(csc_sync_pkg::addr_rxd_delay, 8'h00);
endtask

task automatic agreement_run();
  csc_sync_pkg::marker_t m;
  csc_sync_pkg::marker_t prev;
  test_name = "agreement_run";
  settle_link();
  prev = idle_marker;
  repeat (40) begin
    m = valid_marker(next_tag());
    drive_links(all_links(m));
    @(negedge clock);
    compare_marker("common marker", prev, 1'b1);  // Flags show the crossing before
    compare_bit("lostsync during agreement", 1'b0, lostsync);
    prev = m;
  end
endtask

task automatic loss_and_latch();
  logic [2:0]            t;
  csc_sync_pkg::marker_t m;
  csc_sync_pkg::marker_t odd;
  logic [kw-1:0]         v;
  logic [7:0]            data;
  test_name = "loss_and_latch";
  settle_link();
  t   = next_tag();
  m   = valid_marker(t);
  odd = valid_marker(t + 3'd3);
  v   = all_links(m);
  v[4*8 +: 8] = odd.raw;
  drive_links(all_links(m));
  drive_links(v);  // Link 4 disagrees for one crossing
  drive_links(all_links(m));
  @(negedge clock);
  compare_bit("synced after mismatch", 1'b0, synced);
  compare_bit("lostsync after mismatch", 1'b1, lostsync);
  expect_flags("agreement back", 1'b1, 1'b1);  // Sticky flag holds
  read_reg(csc_sync_pkg::addr_status, data);
  compare_byte("status with loss latched", 8'h03, data);
  write_reg(csc_sync_pkg::addr_status, 8'h00);
  @(negedge clock);
  compare_bit("lostsync after clear", 1'b0, lostsync);
  compare_bit("synced after clear", 1'b1, synced);
endtask

// --------------------------------------------------
// Link qualification
// --------------------------------------------------

task automatic skip_rules();
  logic [2:0]            t;
  csc_sync_pkg::marker_t m;
  csc_sync_pkg::marker_t odd;
  logic [kw-1:0]         v;
  test_name = "skip_rules";
  settle_link();
  t   = next_tag();
  m   = valid_marker(t);
  odd = valid_marker(t + 3'd1);
  v   = all_links(m);
  v[2*8 +: 8] = csc_sync_pkg::marker_overflow;
  drive_links(v);
  expect_flags("overflow link", 1'b1, 1'b0);
  expect_flags("overflow link", 1'b1, 1'b0);
  write_reg(csc_sync_pkg::addr_fiber_enable, 8'h1B);  // Link 2 off
  v[2*8 +: 8] = odd.raw;
  drive_links(v);
  expect_flags("disabled link", 1'b1, 1'b0);
  expect_flags("disabled link", 1'b1, 1'b0);
  drive_links(all_links(m));
  write_reg(csc_sync_pkg::addr_fiber_enable, 8'h1F);
  write_reg(csc_sync_pkg::addr_fiber_enable, 8'h00);  // Every link off
  v[0 +: 8] = 8'hF7;                                   // Not even in the table
  drive_links(v);
  expect_flags("all links skipped", 1'b1, 1'b0);
  drive_links(all_links(m));
  write_reg(csc_sync_pkg::addr_fiber_enable, 8'h1F);
  v = all_links(m);
  v[2*8 +: 8] = odd.raw;
  @(posedge clock);
  link_good[2] <= 1'b0;
  kchar        <= v;
  expect_flags("bad link", 1'b1, 1'b0);
  expect_flags("bad link", 1'b1, 1'b0);
  @(posedge clock);
  link_good[2] <= 1'b1;
  expect_flags("recovering link", 1'b1, 1'b0);  // Two cycles of history still bad
  expect_flags("recovering link", 1'b1, 1'b0);
  expect_flags("recovered link", 1'b0, 1'b1);
  drive_links(all_links(m));
endtask

task automatic invalid_code();
  logic [7:0]            probe [4] = '{8'hF7, 8'h3E, 8'hBC, 8'h7F};
  csc_sync_pkg::marker_t b;
  logic                  exp;
  test_name = "invalid_code";
  settle_link();
  foreach (probe[k]) begin
    b   = probe[k];
    exp = in_table(b);
    drive_links(all_links(b));
    @(posedge clock);
    @(negedge clock);
    compare_marker("uniform marker", b, exp);
    compare_bit("lostsync after uniform marker", !exp, lostsync);
    drive_links(all_links(idle_marker));
    write_reg(csc_sync_pkg::addr_status, 8'h00);
    @(negedge clock);
    compare_bit("lostsync after clear", 1'b0, lostsync);
  end
endtask

// --------------------------------------------------
// Resync-done delay and TTC resync
// --------------------------------------------------

task automatic resync_gating();
  logic [2:0]            t;
  csc_sync_pkg::marker_t m;
  csc_sync_pkg::marker_t odd;
  logic [kw-1:0]         v;
  test_name = "resync_gating";
  settle_link();
  write_reg(csc_sync_pkg::addr_rxd_delay, 8'd3);
  t   = next_tag();
  m   = valid_marker(t);
  odd = valid_marker(t + 3'd5);
  v   = all_links(m);
  v[1*8 +: 8] = odd.raw;
  @(posedge clock);
  sync_done <= '0;               // Links start a resync
  repeat (18) @(posedge clock);  // Sixteen-deep history has drained
  drive_links(v);
  expect_flags("mismatch while idle", 1'b1, 1'b0);
  @(posedge clock);
  sync_done <= '1;
  for (int k = 0; k <= rxd_setting; k++) begin
    expect_flags("before resync done", 1'b1, 1'b0);
  end
  expect_flags("after resync done", 1'b0, 1'b1);
  @(posedge clock);
  ttc_resync <= 1'b1;
  @(posedge clock);
  ttc_resync <= 1'b0;
  kchar      <= all_links(m);
  expect_flags("ttc resync", 1'b1, 1'b0);
  expect_flags("after ttc resync", 1'b1, 1'b0);
  write_reg(csc_sync_pkg::addr_rxd_delay, 8'h00);
endtask

//--- testbench/csc_sync_tb.sv
`timescale 1ns/1ps

module csc_sync_tb;

  localparam int n_links = csc_sync_pkg::n_links_default;
  localparam int kw      = n_links * csc_sync_pkg::marker_bits;  // Flat marker bus width

  // Rough cycle count per test, the watchdog allows twice the total
  localparam int test_cycles = 80 + 90 + 60 + 100 + 70 + 90;
  localparam int ready_limit = 20;  // Power-up is two locked cycles plus the ready flop

  localparam logic [7:0] idle_marker = 8'h1C;  // Tag 0 frame marker

  logic               clock;
  logic               rst;
  logic               clk_lock;
  logic               ttc_resync;
  logic [kw-1:0]      kchar;
  logic [n_links-1:0] link_good;
  logic [n_links-1:0] sync_done;
  logic               reg_we;
  logic [1:0]         reg_addr;
  logic [7:0]         reg_wdata;
  logic [7:0]         reg_rdata;
  logic               synced;
  logic               lostsync;

  int          errors      = 0;
  int          checks      = 0;
  string       test_name   = "none";
  logic [31:0] rng_state   = 32'hf914;
  logic [3:0]  rxd_setting = '0;  // Mirror of the delay register

  csc_sync_top i_csc_sync_top (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [2:0] next_tag();
    rng_state = xorshift32(rng_state);
    return rng_state[2:0];
  endfunction

  // Frame marker for a crossing tag, built from the table rule
  function automatic csc_sync_pkg::marker_t valid_marker(input logic [2:0] tag);
    csc_sync_pkg::marker_t m;
    m.fields.tag  = tag;
    m.fields.code = 4'b1110;
    m.fields.low  = (tag == 3'd7);  // FC is the overflow marker, so tag seven uses FD
    return m;
  endfunction

  function automatic logic in_table(input csc_sync_pkg::marker_t m);
    return m.fields.code == 4'b1110;
  endfunction

  function automatic logic [kw-1:0] all_links(input csc_sync_pkg::marker_t m);
    logic [kw-1:0] v;
    for (int i = 0; i < n_links; i++) begin
      v[i*8 +: 8] = m.raw;  // Same byte on every fiber
    end
    return v;
  endfunction

  task automatic drive_links(input logic [kw-1:0] v);
    @(posedge clock);
    kchar <= v;
  endtask

  // Write strobe is high for one edge only
  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    @(posedge clock);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clock);
    reg_we <= 1'b0;  // Write lands on this edge
    if (addr == csc_sync_pkg::addr_rxd_delay) begin
      rxd_setting = data[3:0];
    end
  endtask

  task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
    @(posedge clock);
    reg_addr <= addr;
    @(negedge clock);
    data = reg_rdata;  // Readback is combinational, settled by mid-cycle
  endtask

  // Bring the links into the monitored state with a clean sticky flag
  task automatic settle_link();
    int waited;
    waited = 0;
    @(posedge clock);
    sync_done <= '1;
    link_good <= '1;
    kchar     <= all_links(idle_marker);
    @(negedge clock);
    while (i_csc_sync_top.i_sync_done_delay.ready !== 1'b1 && waited < ready_limit) begin
      @(negedge clock);
      waited++;
    end
    if (waited >= ready_limit) begin
      errors++;
      $display("Test %s: ready did not rise within %0d cycles", test_name, ready_limit);
    end
    repeat (rxd_setting + 2) @(posedge clock);
    write_reg(csc_sync_pkg::addr_status, 8'h00);
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  task automatic compare_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic compare_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Synced flag seen after every link carried the marker shown
  task automatic compare_marker(input string what, input csc_sync_pkg::marker_t shown,
                                input logic exp);
    checks++;
    if (synced !== exp) begin
      errors++;
      $display("ERROR %s: %s %h expected synced %b actual %b",
               test_name, what, shown.raw, exp, synced);
    end
  endtask

  // One edge for the DUT, then both flags read away from the edge
  task automatic expect_flags(input string what, input logic exp_synced, input logic exp_lost);
    @(posedge clock);
    @(negedge clock);
    compare_bit({what, ": synced"}, exp_synced, synced);
    compare_bit({what, ": lostsync"}, exp_lost, lostsync);
  endtask

  `include "csc_sync_tests.svh"

  // --------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------

  initial begin
    rst        = 1'b1;
    clk_lock   = 1'b1;
    ttc_resync = 1'b0;
    kchar      = all_links(idle_marker);
    link_good  = '1;
    sync_done  = '1;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    repeat (2) @(posedge clock);
    rst <= 1'b0;
    reset_and_registers();
    agreement_run();
    loss_and_latch();
    skip_rules();
    invalid_code();
    resync_gating();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (2 * test_cycles) @(posedge clock);
    $display("Watchdog: run still busy after %0d cycles in test %s", 2 * test_cycles, test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
